// ==== include/rtx_consts.svh ====
`ifndef RTX_CONSTS_SVH
`define RTX_CONSTS_SVH

// one camera vector, three 24-bit fixed-point components
`define VEC_W 72
// one packed scene object
`define OBJ_W 96

// payload lengths that follow the command byte
`define OBJ_BYTES 12
`define CAM_BYTES 9

// object buffer depth
`define MAX_OBJS 128

// default frame size
`define H_PIXELS_DEF 1280
`define V_PIXELS_DEF 720

// camera at reset, origin is zero
`define CAM_FWD_RST   {24'h000000, 24'h000000, 24'h484000}
`define CAM_RIGHT_RST {24'h3f0000, 24'h000000, 24'h000000}
`define CAM_UP_RST    {24'h000000, 24'h3f0000, 24'h000000}

`endif

// ==== logic/scene_pkg.sv ====
`include "rtx_consts.svh"

package scene_pkg;

  // x, y, z packed msb first
  typedef logic [`VEC_W-1:0] vec3_t;
  typedef logic [`OBJ_W-1:0] object_t;

  // index into the object buffer
  typedef logic [$clog2(`MAX_OBJS)-1:0] obj_idx_t;
  // count needs one bit more, it may equal MAX_OBJS
  typedef logic [$clog2(`MAX_OBJS):0] obj_cnt_t;

  // bit 7 set: camera write, bits 1:0 pick the vector
  // bit 7 clear: object write, bits 6:0 are the index
  typedef logic [7:0] flash_cmd_t;

  typedef enum logic [1:0] {IDLE, PAYLOAD, COMMIT} parse_state_t;

endpackage

// ==== logic/video_pkg.sv ====
package video_pkg;

  // rgb565, red in the top bits
  typedef logic [15:0] pixel_t;

  // raster position of a rendered pixel
  typedef logic [10:0] h_count_t;
  typedef logic [9:0] v_count_t;

  // row * width + column, enough for 1280x720
  typedef logic [19:0] fb_addr_t;

endpackage

// ==== logic/flash_cmd_parser.sv ====
`timescale 1ns/1ps
`include "rtx_consts.svh"

module flash_cmd_parser
  import scene_pkg::*;
(
  input  logic       clk_rtx,
  input  logic       sys_rst,

  // byte stream from the uart receiver
  input  logic       byte_valid,
  input  logic [7:0] byte_data,
  output logic       byte_ready,

  // one write per complete command
  output logic       flash_wen,
  output flash_cmd_t flash_cmd,
  output object_t    flash_payload
);

  parse_state_t state;
  // payload bytes still expected
  logic [3:0] bytes_left;
  flash_cmd_t cmd_q;
  object_t payload_q;
  logic byte_take;

  // only the commit cycle refuses a byte
  assign byte_ready = (state != COMMIT);
  assign byte_take = byte_valid && byte_ready;

  assign flash_wen = (state == COMMIT);
  assign flash_cmd = cmd_q;
  assign flash_payload = payload_q;

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      state <= IDLE;
      bytes_left <= '0;
    end else begin
      case (state)
        IDLE: begin
          // command byte sets the payload length by bit 7
          if (byte_take) begin
            bytes_left <= byte_data[7] ? 4'(`CAM_BYTES) : 4'(`OBJ_BYTES);
            state <= PAYLOAD;
          end
        end
        PAYLOAD: begin
          if (byte_take) begin
            bytes_left <= bytes_left - 4'd1;
            // last payload byte
            if (bytes_left == 4'd1) begin
              state <= COMMIT;
            end
          end
        end
        COMMIT: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // command and payload capture
  always_ff @(posedge clk_rtx) begin
    if (byte_take) begin
      if (state == IDLE) begin
        cmd_q <= byte_data;
        // clear so a camera payload leaves the top bits zero
        payload_q <= '0;
      end else begin
        // msb first so new bytes shift in at the bottom
        payload_q <= {payload_q[`OBJ_W-9:0], byte_data};
      end
    end
  end

  // strobe is a single pulse per command
  a_wen_single: assert property (@(posedge clk_rtx) disable iff (sys_rst)
    flash_wen |=> !flash_wen);

  // write issued only once every payload byte is in
  a_commit_count: assert property (@(posedge clk_rtx) disable iff (sys_rst)
    flash_wen |-> bytes_left == 4'd0);

endmodule

// ==== logic/scene_store.sv ====
`timescale 1ns/1ps
`include "rtx_consts.svh"

module scene_store
  import scene_pkg::*;
(
  input  logic       clk_rtx,
  input  logic       sys_rst,

  // writes from the flash parser
  input  logic       flash_wen,
  input  flash_cmd_t flash_cmd,
  input  object_t    flash_payload,

  // renderer read port
  input  obj_idx_t   obj_idx,
  input  obj_cnt_t   num_objs,
  output object_t    obj,

  // camera registers
  output vec3_t      cam_origin,
  output vec3_t      cam_forward,
  output vec3_t      cam_right,
  output vec3_t      cam_up
);

  // object buffer, contents undefined until flashed
  object_t obj_mem [`MAX_OBJS];

  // origin, forward, right, up
  vec3_t cam_q [4];

  logic obj_wen;
  logic cam_wen;
  obj_idx_t wr_idx;

  assign obj_wen = flash_wen && !flash_cmd[7];
  assign cam_wen = flash_wen && flash_cmd[7];
  assign wr_idx = flash_cmd[6:0];

  always_ff @(posedge clk_rtx) begin
    if (obj_wen) begin
      obj_mem[wr_idx] <= flash_payload;
    end
  end

  // registered read
  // indices past the active count read as an empty object
  always_ff @(posedge clk_rtx) begin
    if ({1'b0, obj_idx} < num_objs) begin
      obj <= obj_mem[obj_idx];
    end else begin
      obj <= '0;
    end
  end

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      cam_q[0] <= '0;
      cam_q[1] <= `CAM_FWD_RST;
      cam_q[2] <= `CAM_RIGHT_RST;
      cam_q[3] <= `CAM_UP_RST;
    end else if (cam_wen) begin
      // camera uses the low 72 payload bits
      cam_q[flash_cmd[1:0]] <= flash_payload[`VEC_W-1:0];
    end
  end

  assign cam_origin = cam_q[0];
  assign cam_forward = cam_q[1];
  assign cam_right = cam_q[2];
  assign cam_up = cam_q[3];

  // renderer never asks for more objects than the buffer holds
  a_num_objs_range: assert property (@(posedge clk_rtx) disable iff (sys_rst)
    num_objs <= obj_cnt_t'(`MAX_OBJS));

endmodule

// ==== logic/frame_write_gate.sv ====
`timescale 1ns/1ps
`include "rtx_consts.svh"

module frame_write_gate
  import video_pkg::*;
#(
  parameter int H_PIXELS = `H_PIXELS_DEF,
  parameter int V_PIXELS = `V_PIXELS_DEF
) (
  input  logic     clk_rtx,
  input  logic     sys_rst,

  // memory side status and overwrite control
  input  logic     mem_ready,
  input  logic     force_overwrite,
  input  logic     flash_wen,

  // rendered pixels
  input  logic     pix_valid,
  input  pixel_t   pix_data,
  input  h_count_t pix_h,
  input  v_count_t pix_v,
  output logic     pix_ready,

  // frame buffer write requests
  output logic     wr_valid,
  output fb_addr_t wr_addr,
  output pixel_t   wr_data,
  output logic     wr_overwrite,
  input  logic     wr_ready
);

  logic armed;
  logic overwrite_q;
  logic scene_changed;
  logic pix_take;
  logic last_pix;

  // armed, and output slot free or draining this cycle
  assign pix_ready = armed && (!wr_valid || wr_ready);
  assign pix_take = pix_valid && pix_ready;

  assign last_pix = pix_take
                    && (pix_h == h_count_t'(H_PIXELS - 1))
                    && (pix_v == v_count_t'(V_PIXELS - 1));

  // sticky once memory reports ready
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      armed <= 1'b0;
    end else begin
      armed <= armed | mem_ready;
    end
  end

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      wr_valid <= 1'b0;
    end else if (pix_take) begin
      wr_valid <= 1'b1;
    end else if (wr_ready) begin
      wr_valid <= 1'b0;
    end
  end

  // write fields load only on a new pixel, so they hold while stalled
  always_ff @(posedge clk_rtx) begin
    if (pix_take) begin
      wr_addr <= fb_addr_t'(pix_v) * fb_addr_t'(H_PIXELS) + fb_addr_t'(pix_h);
      wr_data <= pix_data;
      // tag with this frame's flag
      wr_overwrite <= overwrite_q;
    end
  end

  // overwrite flag latched at the frame boundary
  // first frame after reset always overwrites
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      overwrite_q <= 1'b1;
      scene_changed <= 1'b0;
    end else if (last_pix) begin
      // a flash in the boundary cycle still counts
      overwrite_q <= force_overwrite | scene_changed | flash_wen;
      scene_changed <= 1'b0;
    end else if (flash_wen) begin
      scene_changed <= 1'b1;
    end
  end

  a_wr_stable: assert property (@(posedge clk_rtx) disable iff (sys_rst)
    wr_valid && !wr_ready |=> wr_valid && $stable(wr_addr) && $stable(wr_data)
                              && $stable(wr_overwrite));

  // renderer column stays inside the frame
  a_pix_h_range: assert property (@(posedge clk_rtx) disable iff (sys_rst)
    pix_take |-> int'(pix_h) < H_PIXELS);

endmodule

// ==== logic/rtx_flash_top.sv ====
`timescale 1ns/1ps
`include "rtx_consts.svh"

module rtx_flash_top
  import scene_pkg::*;
  import video_pkg::*;
#(
  parameter int H_PIXELS = `H_PIXELS_DEF,
  parameter int V_PIXELS = `V_PIXELS_DEF
) (
  input  logic       clk_rtx,
  input  logic       sys_rst,

  // uart bytes
  input  logic       byte_valid,
  input  logic [7:0] byte_data,
  output logic       byte_ready,

  // scene read by the renderer
  input  obj_idx_t   obj_idx,
  input  obj_cnt_t   num_objs,
  output object_t    obj,
  output vec3_t      cam_origin,
  output vec3_t      cam_forward,
  output vec3_t      cam_right,
  output vec3_t      cam_up,

  // rendered pixels in
  input  logic       pix_valid,
  input  pixel_t     pix_data,
  input  h_count_t   pix_h,
  input  v_count_t   pix_v,
  output logic       pix_ready,

  // frame buffer writes out
  output logic       wr_valid,
  output fb_addr_t   wr_addr,
  output pixel_t     wr_data,
  output logic       wr_overwrite,
  input  logic       wr_ready,
  input  logic       mem_ready,
  input  logic       force_overwrite
);

  // shared flash write bus
  logic flash_wen;
  flash_cmd_t flash_cmd;
  object_t flash_payload;

  flash_cmd_parser u_parser (
    .clk_rtx(clk_rtx),
    .sys_rst(sys_rst),
    .byte_valid(byte_valid),
    .byte_data(byte_data),
    .byte_ready(byte_ready),
    .flash_wen(flash_wen),
    .flash_cmd(flash_cmd),
    .flash_payload(flash_payload)
  );

  scene_store u_scene (
    .clk_rtx(clk_rtx),
    .sys_rst(sys_rst),
    .flash_wen(flash_wen),
    .flash_cmd(flash_cmd),
    .flash_payload(flash_payload),
    .obj_idx(obj_idx),
    .num_objs(num_objs),
    .obj(obj),
    .cam_origin(cam_origin),
    .cam_forward(cam_forward),
    .cam_right(cam_right),
    .cam_up(cam_up)
  );

  // any flash write marks the scene as changed
  frame_write_gate #(
    .H_PIXELS(H_PIXELS),
    .V_PIXELS(V_PIXELS)
  ) u_gate (
    .clk_rtx(clk_rtx),
    .sys_rst(sys_rst),
    .mem_ready(mem_ready),
    .force_overwrite(force_overwrite),
    .flash_wen(flash_wen),
    .pix_valid(pix_valid),
    .pix_data(pix_data),
    .pix_h(pix_h),
    .pix_v(pix_v),
    .pix_ready(pix_ready),
    .wr_valid(wr_valid),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .wr_overwrite(wr_overwrite),
    .wr_ready(wr_ready)
  );

endmodule

// ==== testbench/tb_rtx_flash.sv ====
`timescale 1ns/1ps
`include "rtx_consts.svh"

module tb_rtx_flash
  import scene_pkg::*;
  import video_pkg::*;
;

  localparam int H_PIX = 16;
  localparam int V_PIX = 8;
  localparam int FRAME_PIX = H_PIX * V_PIX;
  localparam int N_OBJ_WR = 6;
  localparam int N_FRAMES = 5;
  // cycles for every byte, pixel and read with room for gaps and stalls
  localparam int BYTES_SENT = 5 * (1 + `CAM_BYTES) + N_OBJ_WR * (1 + `OBJ_BYTES);
  localparam int WATCHDOG = (BYTES_SENT + N_FRAMES * FRAME_PIX + 2 * `MAX_OBJS + 20) * 8;

  logic clk_rtx = 1'b0;
  logic sys_rst, byte_valid, byte_ready, pix_valid, pix_ready;
  logic [7:0] byte_data;
  logic wr_valid, wr_overwrite, wr_ready, mem_ready, force_overwrite;
  obj_idx_t obj_idx;
  obj_cnt_t num_objs;
  object_t obj;
  vec3_t cam_origin, cam_forward, cam_right, cam_up;
  pixel_t pix_data, wr_data;
  h_count_t pix_h;
  v_count_t pix_v;
  fb_addr_t wr_addr;

  // reference models
  vec3_t cam_exp [4];
  object_t obj_exp [`MAX_OBJS];
  logic [`MAX_OBJS-1:0] obj_written = '0;
  object_t rd_exp = '0;
  logic rd_chk = 1'b0;
  fb_addr_t exp_addr [1024];
  pixel_t exp_data [1024];
  logic exp_ovr [1024];
  int wr_ptr = 0;
  int rd_ptr = 0;
  logic ovr_model = 1'b1;
  logic armed_exp = 1'b0;
  // flash commits seen and the count at the last frame end
  int flash_count = 0;
  int frame_mark = 0;
  // payload bytes still due in the current command
  int pay_left = 0;
  logic commit_exp = 1'b0;

  rtx_flash_top #(.H_PIXELS(H_PIX), .V_PIXELS(V_PIX)) UUT (.*);

  always #2 clk_rtx = ~clk_rtx;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  // random back-pressure with ready three cycles in four
  always @(negedge clk_rtx) begin
    wr_ready = ($urandom_range(0, 3) != 0);
  end

  // pixel accept, write drain, overwrite latch and read port models
  always @(posedge clk_rtx) begin
    if (!sys_rst) begin
      // command framing by byte count
      commit_exp <= 1'b0;
      if (byte_valid && byte_ready) begin
        if (pay_left == 0) begin
          pay_left <= byte_data[7] ? `CAM_BYTES : `OBJ_BYTES;
        end else begin
          pay_left <= pay_left - 1;
          if (pay_left == 1) begin
            commit_exp <= 1'b1;
          end
        end
      end
      if (mem_ready) begin
        armed_exp <= 1'b1;
      end
      if (pix_valid && pix_ready) begin
        exp_addr[wr_ptr] <= fb_addr_t'(int'(pix_v) * H_PIX + int'(pix_h));
        exp_data[wr_ptr] <= pix_data;
        exp_ovr[wr_ptr] <= ovr_model;
        wr_ptr <= wr_ptr + 1;
        // frame end picks the flag for the next frame
        if (int'(pix_h) == H_PIX - 1 && int'(pix_v) == V_PIX - 1) begin
          ovr_model <= force_overwrite | (flash_count != frame_mark);
          frame_mark <= flash_count;
        end
      end
      if (wr_valid && wr_ready) begin
        rd_ptr <= rd_ptr + 1;
      end
    end
    // read result expected on the next cycle
    if (int'(obj_idx) < int'(num_objs)) begin
      rd_chk <= obj_written[obj_idx];
      rd_exp <= obj_exp[obj_idx];
    end else begin
      rd_chk <= 1'b1;
      rd_exp <= '0;
    end
  end

  // byte input refused only in the cycle after the last payload byte
  a_byte_ready: assert property (@(posedge clk_rtx) disable iff (sys_rst)
    byte_ready == !commit_exp)
    else abort_run($sformatf("CHECK FAILED byte_ready got %h expected %h",
                             $sampled(byte_ready), !$sampled(commit_exp)));
  a_cam_origin: assert property (@(posedge clk_rtx) disable iff (sys_rst)
    cam_origin == cam_exp[0])
    else abort_run($sformatf("CHECK FAILED cam_origin got %h expected %h",
                             $sampled(cam_origin), $sampled(cam_exp[0])));
  a_cam_forward: assert property (@(posedge clk_rtx) disable iff (sys_rst)
    cam_forward == cam_exp[1])
    else abort_run($sformatf("CHECK FAILED cam_forward got %h expected %h",
                             $sampled(cam_forward), $sampled(cam_exp[1])));
  a_cam_right: assert property (@(posedge clk_rtx) disable iff (sys_rst)
    cam_right == cam_exp[2])
    else abort_run($sformatf("CHECK FAILED cam_right got %h expected %h",
                             $sampled(cam_right), $sampled(cam_exp[2])));
  a_cam_up: assert property (@(posedge clk_rtx) disable iff (sys_rst)
    cam_up == cam_exp[3])
    else abort_run($sformatf("CHECK FAILED cam_up got %h expected %h",
                             $sampled(cam_up), $sampled(cam_exp[3])));
  a_obj_read: assert property (@(posedge clk_rtx) disable iff (sys_rst)
    rd_chk |-> obj == rd_exp)
    else abort_run($sformatf("CHECK FAILED obj got %h expected %h",
                             $sampled(obj), $sampled(rd_exp)));
  // nothing moves before the memory side is ready
  a_gate_closed: assert property (@(posedge clk_rtx) disable iff (sys_rst)
    !armed_exp |-> !pix_ready && !wr_valid)
    else abort_run($sformatf("CHECK FAILED pix_ready got %h wr_valid got %h expected 0 0",
                             $sampled(pix_ready), $sampled(wr_valid)));
  a_wr_pending: assert property (@(posedge clk_rtx) disable iff (sys_rst)
    wr_valid |-> rd_ptr < wr_ptr)
    else abort_run("write request shown with no accepted pixel behind it");
  a_wr_addr: assert property (@(posedge clk_rtx) disable iff (sys_rst)
    wr_valid && wr_ready |-> wr_addr == exp_addr[rd_ptr])
    else abort_run($sformatf("CHECK FAILED wr_addr got %h expected %h",
                             $sampled(wr_addr), $sampled(exp_addr[rd_ptr])));
  a_wr_data: assert property (@(posedge clk_rtx) disable iff (sys_rst)
    wr_valid && wr_ready |-> wr_data == exp_data[rd_ptr])
    else abort_run($sformatf("CHECK FAILED wr_data got %h expected %h",
                             $sampled(wr_data), $sampled(exp_data[rd_ptr])));
  a_wr_ovr: assert property (@(posedge clk_rtx) disable iff (sys_rst)
    wr_valid && wr_ready |-> wr_overwrite == exp_ovr[rd_ptr])
    else abort_run($sformatf("CHECK FAILED wr_overwrite got %h expected %h",
                             $sampled(wr_overwrite), $sampled(exp_ovr[rd_ptr])));

  // entered on a falling edge and returns on the one after the accept
  task automatic send_byte(input logic [7:0] b);
    int gap;
    gap = $urandom_range(0, 2);
    byte_valid = 1'b0;
    repeat (gap) @(negedge clk_rtx);
    byte_valid = 1'b1;
    byte_data = b;
    while (!byte_ready) @(negedge clk_rtx);
    @(negedge clk_rtx);
    byte_valid = 1'b0;
  endtask

  task automatic send_cmd(input flash_cmd_t cmd, input object_t payload);
    int n;
    n = cmd[7] ? `CAM_BYTES : `OBJ_BYTES;
    send_byte(cmd);
    // payload msb first
    for (int k = n - 1; k >= 0; k--) begin
      send_byte(payload[8*k +: 8]);
    end
    // commit edge lies between these two falling edges
    @(negedge clk_rtx);
    if (cmd[7]) begin
      cam_exp[cmd[1:0]] = payload[`VEC_W-1:0];
    end else begin
      obj_exp[cmd[6:0]] = payload;
      obj_written[cmd[6:0]] = 1'b1;
    end
    flash_count = flash_count + 1;
  endtask

  task automatic read_all();
    for (int i = 0; i < `MAX_OBJS; i++) begin
      obj_idx = obj_idx_t'(i);
      @(negedge clk_rtx);
    end
  endtask

  // raster order with idle gaps between pixels
  task automatic stream_pixels(input int first, input int last);
    int gap;
    for (int i = first; i <= last; i++) begin
      gap = $urandom_range(0, 2);
      pix_valid = 1'b0;
      repeat (gap) @(negedge clk_rtx);
      pix_valid = 1'b1;
      pix_h = h_count_t'(i % H_PIX);
      pix_v = v_count_t'(i / H_PIX);
      pix_data = pixel_t'($urandom);
      // ready settles after the back-pressure update
      #1;
      while (!pix_ready) begin
        @(negedge clk_rtx);
        #1;
      end
      @(negedge clk_rtx);
    end
    pix_valid = 1'b0;
  endtask

  initial begin
    repeat (WATCHDOG) @(posedge clk_rtx);
    abort_run("timeout, the run did not finish in time");
  end

  initial begin
    int min_idx;
    obj_idx_t idx;
    void'($urandom(32'h31619a68));
    sys_rst = 1'b1;
    byte_valid = 1'b0;
    byte_data = '0;
    obj_idx = '0;
    num_objs = '0;
    pix_valid = 1'b0;
    pix_data = '0;
    pix_h = '0;
    pix_v = '0;
    wr_ready = 1'b0;
    mem_ready = 1'b0;
    force_overwrite = 1'b0;
    cam_exp[0] = '0;
    cam_exp[1] = `CAM_FWD_RST;
    cam_exp[2] = `CAM_RIGHT_RST;
    cam_exp[3] = `CAM_UP_RST;
    repeat (3) @(negedge clk_rtx);
    sys_rst = 1'b0;
    repeat (2) @(negedge clk_rtx);

    // camera vectors from origin to up
    for (int k = 0; k < 4; k++) begin
      send_cmd(8'h80 + 8'(k), object_t'({$urandom, $urandom, $urandom}));
    end

    // objects at random slots
    min_idx = `MAX_OBJS;
    for (int k = 0; k < N_OBJ_WR; k++) begin
      idx = obj_idx_t'($urandom_range(0, `MAX_OBJS - 1));
      if (int'(idx) < min_idx) begin
        min_idx = int'(idx);
      end
      send_cmd({1'b0, idx}, {$urandom, $urandom, $urandom});
    end

    // full readback then a count that hides most slots
    num_objs = obj_cnt_t'(`MAX_OBJS);
    read_all();
    num_objs = obj_cnt_t'(min_idx + 1);
    read_all();

    // a pixel offered while the gate is closed must not get through
    pix_valid = 1'b1;
    pix_data = pixel_t'($urandom);
    repeat (4) @(negedge clk_rtx);
    pix_valid = 1'b0;
    // one-cycle ready pulse arms the gate for good
    mem_ready = 1'b1;
    @(negedge clk_rtx);
    mem_ready = 1'b0;

    // first frame then a quiet one
    stream_pixels(0, FRAME_PIX - 1);
    stream_pixels(0, FRAME_PIX - 1);
    // camera flash half way through
    stream_pixels(0, FRAME_PIX / 2 - 1);
    send_cmd(8'h81, object_t'({$urandom, $urandom, $urandom}));
    stream_pixels(FRAME_PIX / 2, FRAME_PIX - 1);
    // forced overwrite across the frame end
    force_overwrite = 1'b1;
    stream_pixels(0, FRAME_PIX - 1);
    force_overwrite = 1'b0;
    stream_pixels(0, FRAME_PIX - 1);

    while (rd_ptr != wr_ptr) @(negedge clk_rtx);
    @(negedge clk_rtx);
    if (rd_ptr == N_FRAMES * FRAME_PIX) begin
      $display("test passed");
      $finish;
    end else begin
      abort_run($sformatf("CHECK FAILED write count got %h expected %h",
                          rd_ptr, N_FRAMES * FRAME_PIX));
    end
  end

endmodule

// ==== src.f ====
+incdir+include
logic/scene_pkg.sv
logic/video_pkg.sv
logic/flash_cmd_parser.sv
logic/scene_store.sv
logic/frame_write_gate.sv
logic/rtx_flash_top.sv
testbench/tb_rtx_flash.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_rtx_flash
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulator status is masked by tee, the log search decides
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
